//--- include/tcw_consts.svh
`ifndef TCW_CONSTS_SVH
`define TCW_CONSTS_SVH

// pre-trigger window length and tagged run needed to arm
`define TCW_WINDOW_DEPTH 8

// entries per captured block
`define TCW_BLOCK_DEPTH 32

// one output beat per this many block entries
`define TCW_DECIM 4

// sample data width in bits
`define TCW_SAMPLE_W 32

// credits after reset, equal to the receiver buffer depth
`define TCW_CREDIT_MAX 4

// padding word written after a break
`define TCW_FILL_WORD {`TCW_SAMPLE_W{1'b1}}

`endif

//--- verilog/tcw_types_pkg.sv
`include "tcw_consts.svh"

package tcw_types_pkg;

	// one sensor data word
	typedef logic [`TCW_SAMPLE_W-1:0] sample_t;

	// ring buffer pointer
	typedef logic [$clog2(`TCW_WINDOW_DEPTH)-1:0] win_ptr_t;

	// consecutive tagged samples, must reach the full window depth
	typedef logic [$clog2(`TCW_WINDOW_DEPTH + 1)-1:0] run_cnt_t;

	// entry position inside a block
	typedef logic [$clog2(`TCW_BLOCK_DEPTH)-1:0] blk_idx_t;

	// credit count up to and including the maximum
	typedef logic [$clog2(`TCW_CREDIT_MAX + 1)-1:0] credit_t;

	// all ones
	localparam sample_t FILL_WORD = `TCW_FILL_WORD;

endpackage

//--- verilog/tcw_ctl_pkg.sv
package tcw_ctl_pkg;

	// block sequencer states
	// idle waits for the first entry of a block
	// capture has a block open
	// pad fills the rest of a block after a break
	// stall holds a beat until a credit arrives
	typedef enum logic [1:0] {
		IDLE,
		CAPTURE,
		PAD,
		STALL
	} seq_state_e;

endpackage

//--- verilog/tcw_ifs.sv
`timescale 1ns/1ns

// window side to sequencer
interface window_if;
	// pulse one cycle after an accepted sample
	logic stb;
	// oldest sample held in the ring
	tcw_types_pkg::sample_t oldest;
	logic armed;
	// no tag set in the whole window
	logic quiet;
	// sequencer ends the capture
	logic disarm;
	// sequencer stops input acceptance
	logic hold;

	modport win (output stb, output oldest, output armed, output quiet,
		input disarm, input hold);
	modport seq (input stb, input oldest, input armed, input quiet,
		output disarm, output hold);
endinterface

// sequencer to credit transmitter
interface beat_if;
	logic valid;
	tcw_types_pkg::sample_t data;
	// final beat of a block
	logic last;
	// at least one credit left
	logic has_credit;

	modport seq (output valid, output data, output last, input has_credit);
	modport tx (input valid, input data, input last, output has_credit);
endinterface

//--- verilog/sample_window.sv
`timescale 1ns/1ns
`include "tcw_consts.svh"

module sample_window (
	input logic clk,
	input logic rst_n,
	input logic sample_valid_i,
	input tcw_types_pkg::sample_t sample_data_i,
	input logic sample_tag_i,
	output logic sample_ready_o,
	window_if.win w
);
	// pointer wrap point and the run length that arms
	localparam tcw_types_pkg::win_ptr_t LAST_PTR =
		tcw_types_pkg::win_ptr_t'(`TCW_WINDOW_DEPTH - 1);
	localparam tcw_types_pkg::run_cnt_t ARM_CNT =
		tcw_types_pkg::run_cnt_t'(`TCW_WINDOW_DEPTH);

	tcw_types_pkg::sample_t ring [`TCW_WINDOW_DEPTH];
	logic [`TCW_WINDOW_DEPTH-1:0] tag_vec;
	tcw_types_pkg::win_ptr_t wr_ptr;
	tcw_types_pkg::run_cnt_t run_cnt;
	logic armed_q;
	logic stb_q;
	logic accept;

	// input stalls only while the sequencer holds
	assign sample_ready_o = !w.hold;
	assign accept = sample_valid_i && sample_ready_o;

	// sample data ring
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			ring[wr_ptr] <= sample_data_i;
		end
	end

	// tag history, write pointer and strobe
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tag_vec <= '0;
			wr_ptr <= '0;
			stb_q <= 1'b0;
		end
		else
		begin
			stb_q <= accept;
			if (accept)
			begin
				tag_vec[wr_ptr] <= sample_tag_i;
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
		end
	end

	// run counter and arming
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			run_cnt <= '0;
			armed_q <= 1'b0;
		end
		else if (w.disarm)
		begin
			run_cnt <= '0;
			armed_q <= 1'b0;
		end
		else if (accept)
		begin
			if (sample_tag_i)
			begin
				// saturate at the window depth
				if (run_cnt != ARM_CNT)
				begin
					run_cnt <= run_cnt + 1'b1;
				end
				if (run_cnt == ARM_CNT - 1'b1)
				begin
					armed_q <= 1'b1;
				end
			end
			else if (!armed_q)
			begin
				// run broken before arming
				run_cnt <= '0;
			end
		end
	end

	assign w.stb = stb_q;
	assign w.armed = armed_q;
	// pointer has moved past the newest entry, so it sits on the oldest
	assign w.oldest = ring[wr_ptr];
	assign w.quiet = ~|tag_vec;

	// an armed window always holds a full tagged run
	a_armed_run: assert property (@(posedge clk) disable iff (!rst_n)
		armed_q |-> (run_cnt == ARM_CNT));

endmodule

//--- verilog/block_sequencer.sv
`timescale 1ns/1ns
`include "tcw_consts.svh"

module block_sequencer (
	input logic clk,
	input logic rst_n,
	window_if.seq w,
	beat_if.seq b
);
	// final entry and closing beat of a block
	localparam tcw_types_pkg::blk_idx_t LAST_IDX =
		tcw_types_pkg::blk_idx_t'(`TCW_BLOCK_DEPTH - 1);
	localparam tcw_types_pkg::blk_idx_t LAST_BEAT_IDX =
		tcw_types_pkg::blk_idx_t'(`TCW_BLOCK_DEPTH - `TCW_DECIM);

	tcw_ctl_pkg::seq_state_e state;
	tcw_types_pkg::blk_idx_t idx;
	tcw_types_pkg::sample_t stall_data;
	logic stall_last;
	logic pend_quiet;
	logic in_pad;
	logic in_stall;
	logic take;
	logic is_beat;
	logic blocked;
	logic append;
	logic stall_go;
	logic release_beat;

	assign in_pad = (state == tcw_ctl_pkg::PAD);
	assign in_stall = (state == tcw_ctl_pkg::STALL);
	// window entry arrives while a capture is running
	assign take = w.stb && w.armed && !in_pad && !in_stall;
	assign is_beat = ((idx % `TCW_DECIM) == 0);
	// beat wanted but no credit
	assign blocked = (take || in_pad) && is_beat && !b.has_credit;
	// captured entries always advance, pad steps only with credit
	assign append = take || (in_pad && !blocked);
	assign stall_go = take && blocked;
	assign release_beat = in_stall && b.has_credit;

	// beat straight from state, or the held one in stall
	assign b.valid = in_stall || ((take || in_pad) && is_beat);
	assign b.data = in_stall ? stall_data :
		(in_pad ? tcw_types_pkg::FILL_WORD : w.oldest);
	assign b.last = in_stall ? stall_last : (idx == LAST_BEAT_IDX);

	// also stop input in the cycle that enters stall or pad
	assign w.hold = in_pad || in_stall || (take && (w.quiet || blocked));

	// end of the padded block on whichever path reaches it
	assign w.disarm = (take && !blocked && w.quiet && idx == LAST_IDX)
		|| (in_pad && !blocked && idx == LAST_IDX)
		|| (release_beat && pend_quiet && idx == '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= tcw_ctl_pkg::IDLE;
			idx <= '0;
			pend_quiet <= 1'b0;
		end
		else
		begin
			if (append)
			begin
				idx <= (idx == LAST_IDX) ? '0 : idx + 1'b1;
			end
			case (state)
				tcw_ctl_pkg::IDLE, tcw_ctl_pkg::CAPTURE:
				begin
					if (take)
					begin
						if (blocked)
						begin
							state <= tcw_ctl_pkg::STALL;
							pend_quiet <= w.quiet;
						end
						else if (idx == LAST_IDX)
						begin
							// block complete whether quiet or not
							state <= tcw_ctl_pkg::IDLE;
						end
						else if (w.quiet)
						begin
							state <= tcw_ctl_pkg::PAD;
						end
						else
						begin
							state <= tcw_ctl_pkg::CAPTURE;
						end
					end
				end
				tcw_ctl_pkg::PAD:
				begin
					if (!blocked && idx == LAST_IDX)
					begin
						state <= tcw_ctl_pkg::IDLE;
					end
				end
				tcw_ctl_pkg::STALL:
				begin
					if (b.has_credit)
					begin
						// index already points past the held entry
						if (idx == '0)
						begin
							state <= tcw_ctl_pkg::IDLE;
						end
						else if (pend_quiet)
						begin
							state <= tcw_ctl_pkg::PAD;
						end
						else
						begin
							state <= tcw_ctl_pkg::CAPTURE;
						end
					end
				end
				default:
				begin
					state <= tcw_ctl_pkg::IDLE;
				end
			endcase
		end
	end

	// held beat while waiting for credit
	always_ff @(posedge clk)
	begin
		if (stall_go)
		begin
			stall_data <= w.oldest;
			stall_last <= (idx == LAST_BEAT_IDX);
		end
	end

	// a beat without credit stays on the bus unchanged
	a_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
		(b.valid && !b.has_credit) |=> (b.valid && $stable(b.data)
			&& $stable(b.last)));

endmodule

//--- verilog/credit_tx.sv
`timescale 1ns/1ns
`include "tcw_consts.svh"

module credit_tx (
	input logic clk,
	input logic rst_n,
	beat_if.tx b,
	input logic credit_i,
	output logic out_valid_o,
	output tcw_types_pkg::sample_t out_data_o,
	output logic out_last_o
);
	localparam tcw_types_pkg::credit_t CREDIT_MAX =
		tcw_types_pkg::credit_t'(`TCW_CREDIT_MAX);

	tcw_types_pkg::credit_t credits;
	logic xfer;

	assign b.has_credit = (credits != '0);
	// beat leaves the sequencer
	assign xfer = b.valid && b.has_credit;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			credits <= CREDIT_MAX;
			out_valid_o <= 1'b0;
			out_last_o <= 1'b0;
		end
		else
		begin
			// spend and refill may meet in one cycle
			case ({xfer, credit_i})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			out_valid_o <= xfer;
			out_last_o <= xfer && b.last;
		end
	end

	// output data word
	always_ff @(posedge clk)
	begin
		if (xfer)
		begin
			out_data_o <= b.data;
		end
	end

	// receiver never returns more credits than its buffer holds
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		(credit_i && !xfer) |=> (credits <= CREDIT_MAX));

endmodule

//--- verilog/tcw_top.sv
`timescale 1ns/1ns

module tcw_top (
	input logic clk,
	input logic rst_n,
	// upstream samples
	input logic sample_valid_i,
	input tcw_types_pkg::sample_t sample_data_i,
	input logic sample_tag_i,
	output logic sample_ready_o,
	// receiver side
	output logic out_valid_o,
	output tcw_types_pkg::sample_t out_data_o,
	output logic out_last_o,
	input logic credit_i
);
	window_if win_bus ();
	beat_if beat_bus ();

	// ring buffer and arming
	sample_window sample_window_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_valid_i (sample_valid_i),
		.sample_data_i  (sample_data_i),
		.sample_tag_i   (sample_tag_i),
		.sample_ready_o (sample_ready_o),
		.w              (win_bus.win)
	);

	// block capture, padding and decimation
	block_sequencer block_sequencer_i (
		.clk   (clk),
		.rst_n (rst_n),
		.w     (win_bus.seq),
		.b     (beat_bus.seq)
	);

	// credit counting and registered output
	credit_tx credit_tx_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.b           (beat_bus.tx),
		.credit_i    (credit_i),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_data_o),
		.out_last_o  (out_last_o)
	);

endmodule

//--- verif/tb_tcw.sv
`timescale 1ns/1ns
`include "tcw_consts.svh"

module tb_tcw;

	// phase table with one row per phase
	// count of samples, tag level, credits withheld until stall
	localparam int NPH = 7;
	localparam int PH_COUNT [NPH] = '{7, 1, 83, 8, 10, 48, 8};
	localparam int PH_TAG [NPH] = '{1, 0, 1, 0, 0, 1, 0};
	localparam int PH_HOLD [NPH] = '{0, 0, 0, 0, 0, 1, 0};

	logic clk;
	logic rst_n;
	logic sample_valid_i;
	tcw_types_pkg::sample_t sample_data_i;
	logic sample_tag_i;
	logic sample_ready_o;
	logic out_valid_o;
	tcw_types_pkg::sample_t out_data_o;
	logic out_last_o;
	logic credit_i;

	// reference model state
	tcw_types_pkg::sample_t data_hist [$];
	logic tag_hist [$];
	tcw_types_pkg::sample_t exp_data [$];
	logic exp_last [$];
	int m_run;
	bit m_armed;
	int m_idx;

	// receiver side bookkeeping
	int owed;
	int held;
	bit withhold;
	bit stall_seen;
	integer seed;
	tcw_types_pkg::sample_t want_data;
	logic want_last;

	tcw_top dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.sample_valid_i (sample_valid_i),
		.sample_data_i  (sample_data_i),
		.sample_tag_i   (sample_tag_i),
		.sample_ready_o (sample_ready_o),
		.out_valid_o    (out_valid_o),
		.out_data_o     (out_data_o),
		.out_last_o     (out_last_o),
		.credit_i       (credit_i)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// every DECIM-th block entry becomes a beat
	task automatic add_entry(input tcw_types_pkg::sample_t d);
		if (m_idx % `TCW_DECIM == 0)
		begin
			exp_data.push_back(d);
			exp_last.push_back(m_idx == `TCW_BLOCK_DEPTH - `TCW_DECIM);
		end
		m_idx = (m_idx + 1) % `TCW_BLOCK_DEPTH;
	endtask

	// model of one accepted sample
	task automatic model_accept(input tcw_types_pkg::sample_t d, input logic tag);
		bit quiet;
		int n;
		data_hist.push_back(d);
		tag_hist.push_back(tag);
		n = data_hist.size();
		if (tag)
		begin
			if (m_run < `TCW_WINDOW_DEPTH)
				m_run++;
			if (m_run == `TCW_WINDOW_DEPTH)
				m_armed = 1'b1;
		end
		else if (!m_armed)
		begin
			m_run = 0;
		end
		if (m_armed)
		begin
			quiet = 1'b1;
			for (int k = 0; k < `TCW_WINDOW_DEPTH; k++)
			begin
				if (tag_hist[n-1-k])
					quiet = 1'b0;
			end
			// entry is the sample WINDOW_DEPTH-1 accepts back
			add_entry(data_hist[n-`TCW_WINDOW_DEPTH]);
			if (quiet)
			begin
				// break pads out the open block, then disarm
				while (m_idx != 0)
					add_entry(tcw_types_pkg::FILL_WORD);
				m_armed = 1'b0;
				m_run = 0;
			end
		end
	endtask

	// present one sample and wait until it is taken
	task automatic drive_sample(input tcw_types_pkg::sample_t d, input logic tag);
		int waited;
		@(posedge clk);
		#2;
		sample_valid_i = 1'b1;
		sample_data_i = d;
		sample_tag_i = tag;
		waited = 0;
		@(negedge clk);
		while (!sample_ready_o)
		begin
			waited++;
			// stalled long enough, let the receiver refill
			if (withhold && waited >= 12)
			begin
				stall_seen = 1'b1;
				withhold = 1'b0;
			end
			if (waited > 200)
			begin
				$display("sample_ready_o stayed low for %0d cycles at %0t", waited, $time);
				$display("Test failures found");
				$fatal(1);
			end
			@(negedge clk);
		end
		model_accept(d, tag);
	endtask

	// credit return with one pulse per owed beat
	initial
	begin
		forever
		begin
			@(posedge clk);
			#2;
			if (rst_n && !withhold && owed > 0)
			begin
				credit_i = 1'b1;
				owed--;
			end
			else
			begin
				credit_i = 1'b0;
			end
		end
	end

	// beat monitor checks in order against the model queue
	always @(negedge clk)
	begin
		if (rst_n && out_valid_o)
		begin
			if (exp_data.size() == 0)
			begin
				$display("unexpected beat with data %h at %0t", out_data_o, $time);
				$display("Test failures found");
				$fatal(1);
			end
			else
			begin
				want_data = exp_data.pop_front();
				want_last = exp_last.pop_front();
				check_value("out_data_o", out_data_o, want_data);
				check_value("out_last_o", out_last_o, want_last);
				owed++;
				if (withhold)
					held++;
				if (held > `TCW_CREDIT_MAX)
				begin
					$display("more beats than credits while credits were withheld");
					$display("Test failures found");
					$fatal(1);
				end
			end
		end
	end

	// watchdog sized from the table
	initial
	begin
		int total;
		total = 0;
		for (int p = 0; p < NPH; p++)
			total += PH_COUNT[p];
		#((total * 20 + 16 + 400) * 40);
		$display("watchdog expired, the run did not finish in time");
		$display("Test failures found");
		$fatal(1);
	end

	initial
	begin
		tcw_types_pkg::sample_t d;
		int tag_seq;
		int drain_wait;
		seed = 32'h36ff26f3;
		rst_n = 1'b0;
		sample_valid_i = 1'b0;
		sample_data_i = '0;
		sample_tag_i = 1'b0;
		credit_i = 1'b0;
		owed = 0;
		held = 0;
		withhold = 1'b0;
		stall_seen = 1'b0;
		m_run = 0;
		m_armed = 1'b0;
		m_idx = 0;
		tag_seq = 0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// idle after reset
		repeat (8)
		begin
			@(negedge clk);
			check_value("sample_ready_o", sample_ready_o, 1);
			check_value("out_valid_o", out_valid_o, 0);
		end

		for (int p = 0; p < NPH; p++)
		begin
			withhold = PH_HOLD[p];
			held = 0;
			stall_seen = 1'b0;
			for (int s = 0; s < PH_COUNT[p]; s++)
			begin
				// tagged words count up, untagged ones are random
				if (PH_TAG[p] != 0)
				begin
					d = 32'h5a00_0000 + tag_seq;
					tag_seq++;
				end
				else
				begin
					d = $random(seed);
				end
				drive_sample(d, PH_TAG[p] != 0);
			end
			if (PH_HOLD[p] != 0)
				check_value("sample_ready_o stall", stall_seen, 1);
			withhold = 1'b0;
		end
		@(posedge clk);
		#2;
		sample_valid_i = 1'b0;

		// wait a bounded time for the drain and then for stray beats
		drain_wait = 0;
		while (exp_data.size() != 0 && drain_wait < 400)
		begin
			@(negedge clk);
			drain_wait++;
		end
		repeat (40) @(negedge clk);
		if (exp_data.size() != 0)
		begin
			$display("%0d expected beats never arrived", exp_data.size());
			$display("Test failures found");
			$fatal(1);
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

//--- tcw.f
+incdir+include
verilog/tcw_types_pkg.sv
verilog/tcw_ctl_pkg.sv
verilog/tcw_ifs.sv
verilog/sample_window.sv
verilog/block_sequencer.sv
verilog/credit_tx.sv
verilog/tcw_top.sv
verif/tb_tcw.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f tcw.f --top-module tb_tcw -o tb_tcw
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_tcw > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
fi

if grep -q "All tests passed!" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
